//--- Bender.yml
package:
  name: l2c

sources:
  - source/l2c_pkg.sv
  - source/l2c_tag_store.sv
  - source/l2c_line_store.sv
  - source/l2c_plru.sv
  - source/l2c_ctrl.sv
  - source/l2c_top.sv
  - target: simulation
    files:
      - sim/l2c_mem_model.sv
      - sim/tb_l2c.sv

//--- sim/l2c_mem_model.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone classic memory slave for the L2 cache testbench.
// One 512-bit line per bus cycle. Ack comes latency+1 cycles after stb.
// Unwritten word w reads as w replicated four times in 32-bit fields.
// Every transfer is logged as we, line address and line data.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module l2c_mem_model #(
    parameter int latency = 3
) (
    input  wire                     clk_tmp,
    input  wire                     rst,
    input  wire l2c_pkg::wb_m2s_t   wb_i,
    output l2c_pkg::wb_s2m_t        wb_o
);
    import l2c_pkg::*;

    logic [addr_w-off_bits-1:0] store_adr_q [$];
    line_t                      store_dat_q [$];
    logic                       log_we_q    [$];
    logic [addr_w-off_bits-1:0] log_adr_q   [$];
    line_t                      log_dat_q   [$];
    int                         wait_q;

    function automatic line_t read_line(input logic [addr_w-off_bits-1:0] la);
        line_t             l;
        logic [addr_w-1:0] wa;
        for (int i = 0; i < 4; i++) begin
            wa = {la, i[1:0]};
            l[i*word_w +: word_w] = {4{wa}};
        end
        for (int k = 0; k < store_adr_q.size(); k++) begin
            if (store_adr_q[k] == la) begin
                l = store_dat_q[k];   // latest write wins
            end
        end
        return l;
    endfunction

    always @(posedge clk_tmp) begin
        if (rst) begin
            wb_o.ack <= 1'b0;
            wait_q   <= 0;
        end else begin
            wb_o.ack <= 1'b0;
            if (wb_i.cyc && wb_i.stb && !wb_o.ack) begin
                if (wait_q == latency) begin
                    wait_q   <= 0;
                    wb_o.ack <= 1'b1;
                    log_we_q.push_back(wb_i.we);
                    log_adr_q.push_back(wb_i.adr);
                    log_dat_q.push_back(wb_i.dat);
                    if (wb_i.we) begin
                        store_adr_q.push_back(wb_i.adr);
                        store_dat_q.push_back(wb_i.dat);
                    end else begin
                        wb_o.dat <= read_line(wb_i.adr);
                    end
                end else begin
                    wait_q <= wait_q + 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/l2c_vectors.txt
# op(0 rd,1 wr) addr wdata expected_rdata latency bus_reads write_back wb_addr hold
# latency 0 is not checked, rdata is not checked on writes
0 00000010 00000000000000000000000000000000 00000001000000010000000100000001 0 1 0 00000000 0
0 00000010 00000000000000000000000000000000 00000001000000010000000100000001 2 0 0 00000000 3
1 00000020 0123456789abcdeffedcba9876543210 00000000000000000000000000000000 2 0 0 00000000 0
0 00000000 00000000000000000000000000000000 00000000000000000000000000000000 2 0 0 00000000 0
0 00000010 00000000000000000000000000000000 00000001000000010000000100000001 2 0 0 00000000 0
0 00000020 00000000000000000000000000000000 0123456789abcdeffedcba9876543210 2 0 0 00000000 1
0 00000030 00000000000000000000000000000000 00000003000000030000000300000003 2 0 0 00000000 0
0 00000400 00000000000000000000000000000000 00000040000000400000004000000040 0 1 0 00000000 0
0 00000800 00000000000000000000000000000000 00000080000000800000008000000080 0 1 0 00000000 0
0 00000c00 00000000000000000000000000000000 000000c0000000c0000000c0000000c0 0 1 0 00000000 0
0 00001000 00000000000000000000000000000000 00000100000001000000010000000100 0 1 1 00000000 2
0 00000020 00000000000000000000000000000000 0123456789abcdeffedcba9876543210 0 1 0 00000000 0
0 00000800 00000000000000000000000000000000 00000080000000800000008000000080 0 1 0 00000000 0
0 00000c00 00000000000000000000000000000000 000000c0000000c0000000c0000000c0 2 0 0 00000000 0
0 00001010 00000000000000000000000000000000 00000101000001010000010100000101 2 0 0 00000000 0
1 00000040 a5a5a5a55a5a5a5a0f0f0f0ff0f0f0f0 00000000000000000000000000000000 0 1 0 00000000 0
0 00000040 00000000000000000000000000000000 a5a5a5a55a5a5a5a0f0f0f0ff0f0f0f0 2 0 0 00000000 0
0 00000050 00000000000000000000000000000000 00000005000000050000000500000005 2 0 0 00000000 0

//--- sim/tb_l2c.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for l2c_top, run from the project root.
// Vectors come from sim/l2c_vectors.txt, one request per line.
// Expected write-back lines are rebuilt from the memory pattern and
// the processor writes seen so far. Stops at the first mismatch.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module tb_l2c;
    import l2c_pkg::*;

    typedef struct packed {
        logic              write;
        logic [addr_w-1:0] addr;
        word_t             wdata;
        word_t             rdata;
        logic [7:0]        lat;      // 0 means not checked
        logic [7:0]        reads;
        logic              wb;
        logic [addr_w-1:0] wb_addr;
        logic [7:0]        hold;     // cycles with complete held low
    } vector_t;

    localparam int clk_period = 20;
    localparam int wait_limit = 50;

    logic              clk_tmp;
    logic              rst;
    logic              complete;
    logic              loaded;
    cpu_req_t          req;
    cpu_rsp_t          rsp;
    wb_m2s_t           wb_m2s;
    wb_s2m_t           wb_s2m;
    vector_t           vec_q     [$];
    logic [addr_w-1:0] wr_adr_q  [$];   // word addresses written so far
    word_t             wr_dat_q  [$];

    l2c_top #(.set_bits(default_set_bits)) DUT (
        .clk_tmp  (clk_tmp),
        .rst      (rst),
        .req      (req),
        .complete (complete),
        .rsp      (rsp),
        .wb_o     (wb_m2s),
        .wb_i     (wb_s2m)
    );

    l2c_mem_model #(.latency(3)) mem (
        .clk_tmp (clk_tmp),
        .rst     (rst),
        .wb_i    (wb_m2s),
        .wb_o    (wb_s2m)
    );

    always #(clk_period / 2) clk_tmp = ~clk_tmp;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [line_w-1:0] got,
                             input logic [line_w-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("ERR %s got %0h expected %0h", name, got, exp));
        end
    endtask

    function automatic line_t expected_line(input logic [addr_w-off_bits-1:0] la);
        line_t             l;
        logic [addr_w-1:0] wa;
        for (int i = 0; i < 4; i++) begin
            wa = {la, i[1:0]};
            l[i*word_w +: word_w] = {4{wa}};
            for (int k = 0; k < wr_adr_q.size(); k++) begin
                if (wr_adr_q[k] == wa) begin
                    l[i*word_w +: word_w] = wr_dat_q[k];
                end
            end
        end
        return l;
    endfunction

    task automatic load_vectors();
        int                fd;
        int                n;
        int                op;
        int                lat;
        int                reads;
        int                wb;
        int                hold;
        string             line;
        logic [addr_w-1:0] addr;
        logic [addr_w-1:0] wb_addr;
        word_t             wdata;
        word_t             rdata;
        fd = $fopen("sim/l2c_vectors.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open the vector file sim/l2c_vectors.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%d %h %h %h %d %d %d %h %d", op, addr, wdata,
                                rdata, lat, reads, wb, wb_addr, hold);
                    if (n != 9) begin
                        fail_run($sformatf("malformed vector line: %s", line));
                    end
                    vec_q.push_back('{op[0], addr, wdata, rdata, lat[7:0], reads[7:0],
                                      wb[0], wb_addr, hold[7:0]});
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_bus(input vector_t v, input int base);
        int idx;
        check_val("bus transfers", mem.log_we_q.size() - base, v.reads + v.wb);
        idx = base;
        if (v.wb) begin   // write-back must come before the refill read
            check_val("wb_o.we", mem.log_we_q[idx], 1'b1);
            check_val("wb_o.adr", mem.log_adr_q[idx], v.wb_addr[addr_w-1:off_bits]);
            check_val("wb_o.dat", mem.log_dat_q[idx],
                      expected_line(v.wb_addr[addr_w-1:off_bits]));
            idx++;
        end
        if (v.reads != 0) begin
            check_val("wb_o.we", mem.log_we_q[idx], 1'b0);
            check_val("wb_o.adr", mem.log_adr_q[idx], v.addr[addr_w-1:off_bits]);
        end
    endtask

    task automatic run_vector(input vector_t v, input int num);
        int    edges;
        int    base;
        base      = mem.log_we_q.size();
        req.valid = 1'b1;
        req.write = v.write;
        req.addr  = v.addr;
        req.wdata = v.wdata;
        edges     = 0;
        do begin
            @(posedge clk_tmp);
            #2;
            edges++;
        end while (!rsp.ready && edges < wait_limit);
        if (!rsp.ready) begin
            fail_run($sformatf("vector %0d saw no ready within %0d cycles", num, wait_limit));
        end
        if (!v.write) begin
            check_val("rsp.rdata", rsp.rdata, v.rdata);
        end
        if (v.lat != 0) begin
            check_val("ready latency", edges, v.lat);
        end
        check_bus(v, base);
        repeat (v.hold) begin   // ready and word must not move while complete is low
            @(posedge clk_tmp);
            #2;
            check_val("rsp.ready", rsp.ready, 1'b1);
            if (!v.write) begin
                check_val("rsp.rdata", rsp.rdata, v.rdata);
            end
        end
        complete  = 1'b1;
        req.valid = 1'b0;
        @(posedge clk_tmp);
        #2;
        complete = 1'b0;
        check_val("rsp.ready", rsp.ready, 1'b0);
        if (v.write) begin
            wr_adr_q.push_back(v.addr >> 4);
            wr_dat_q.push_back(v.wdata);
        end
    endtask

    initial begin
        clk_tmp   = 1'b0;
        rst       = 1'b1;
        complete  = 1'b0;
        loaded    = 1'b0;
        req       = '0;
        load_vectors();
        loaded = 1'b1;
        repeat (2) @(posedge clk_tmp);
        #2;
        rst = 1'b0;
        check_val("rsp.ready", rsp.ready, 1'b0);
        check_val("wb_o.cyc", wb_m2s.cyc, 1'b0);
        check_val("wb_o.stb", wb_m2s.stb, 1'b0);
        foreach (vec_q[i]) begin
            run_vector(vec_q[i], i);
        end
        $display("No errors");
        $finish;
    end

    // run limit from the vector count
    initial begin
        wait (loaded);
        #((vec_q.size() * 60 + 20) * clk_period);
        fail_run("watchdog expired, the cache never finished the vectors");
    end

endmodule

`default_nettype wire

//--- source/l2c_ctrl.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cache control FSM and Wishbone classic master, one line per bus cycle.
// One request at a time. The requester holds req stable until ready.
// A dirty victim is written back, then the line is read and the FSM
// returns to lookup so the final access always takes the hit path.
// Write-back and refill are separated by one cycle with cyc low.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module l2c_ctrl #(
    parameter int  set_bits = l2c_pkg::default_set_bits,
    localparam int tag_w    = l2c_pkg::addr_w - set_bits - l2c_pkg::off_bits
) (
    input  wire                                 clk_tmp,
    input  wire                                 rst,
    input  wire l2c_pkg::cpu_req_t              req,
    input  wire                                 complete,
    output l2c_pkg::cpu_rsp_t                   rsp,
    input  wire                                 hit,
    input  wire                                 victim_valid,
    input  wire                                 victim_dirty,
    input  wire [tag_w-1:0]                     victim_tag,
    input  wire l2c_pkg::line_t                 rd_line,
    input  wire l2c_pkg::word_t                 rd_word,
    output logic [set_bits-1:0]                 index,
    output logic [tag_w-1:0]                    tag,
    output logic [l2c_pkg::word_sel_bits-1:0]   word_sel,
    output logic                                tag_we,
    output logic                                dirty_we,
    output logic                                fill_we,
    output logic                                merge_we,
    output logic                                access,
    output l2c_pkg::line_t                      fill_line,
    output l2c_pkg::word_t                      merge_word,
    output l2c_pkg::wb_m2s_t                    wb_o,
    input  wire l2c_pkg::wb_s2m_t               wb_i
);
    import l2c_pkg::*;

    ctrl_state_t                state_q;
    logic                       cyc_q;
    logic                       we_q;
    logic [addr_w-off_bits-1:0] adr_q;
    line_t                      dat_q;
    word_t                      rdata_q;
    logic                       lookup_hit;
    logic                       refill_done;
    logic                       need_wb;

    assign index    = req.addr[off_bits +: set_bits];
    assign tag      = req.addr[addr_w-1 -: tag_w];
    assign word_sel = req.addr[off_bits-1 -: word_sel_bits];

    assign lookup_hit  = (state_q == lookup) && hit;
    assign refill_done = (state_q == refill) && cyc_q && wb_i.ack;
    assign need_wb     = victim_valid && victim_dirty;

    assign access     = lookup_hit;
    assign merge_we   = lookup_hit && req.write;
    assign dirty_we   = merge_we;
    assign fill_we    = refill_done;
    assign tag_we     = refill_done;   // line and tag go in together
    assign fill_line  = wb_i.dat;
    assign merge_word = req.wdata;

    assign rsp  = '{ready: (state_q == respond), rdata: rdata_q};
    assign wb_o = '{cyc: cyc_q, stb: cyc_q, we: we_q, adr: adr_q, dat: dat_q};

    always_ff @(posedge clk_tmp) begin
        if (rst) begin
            state_q <= idle;
            cyc_q   <= 1'b0;
            we_q    <= 1'b0;
        end else begin
            case (state_q)
                idle: begin
                    if (req.valid) begin
                        state_q <= lookup;
                    end
                end
                lookup: begin
                    if (hit) begin
                        state_q <= respond;
                    end else begin
                        cyc_q   <= 1'b1;
                        we_q    <= need_wb;
                        state_q <= need_wb ? write_back : refill;
                    end
                end
                write_back: begin
                    if (wb_i.ack) begin
                        cyc_q   <= 1'b0;
                        we_q    <= 1'b0;
                        state_q <= refill;
                    end
                end
                refill: begin
                    if (refill_done) begin
                        cyc_q   <= 1'b0;
                        state_q <= lookup;
                    end else if (!cyc_q) begin
                        cyc_q <= 1'b1;   // read after a write-back
                    end
                end
                respond: begin
                    if (complete) begin
                        state_q <= idle;
                    end
                end
                default: state_q <= idle;
            endcase
        end
    end

    // bus address and data, read word
    always_ff @(posedge clk_tmp) begin
        if (lookup_hit && !req.write) begin
            rdata_q <= rd_word;
        end
        if ((state_q == lookup) && !hit) begin
            if (need_wb) begin
                adr_q <= {victim_tag, index};   // victim's own line address
                dat_q <= rd_line;
            end else begin
                adr_q <= req.addr[addr_w-1:off_bits];
            end
        end else if ((state_q == write_back) && wb_i.ack) begin
            adr_q <= req.addr[addr_w-1:off_bits];
        end
    end

endmodule

`default_nettype wire

//--- source/l2c_line_store.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Line data array, one 512-bit line per way and set.
// Reads are combinational. Fill and merge are written at the clock edge.
// Fill takes priority over merge if both are raised.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module l2c_line_store #(
    parameter int set_bits = l2c_pkg::default_set_bits
) (
    input  wire                                 clk_tmp,
    input  wire [set_bits-1:0]                  index,
    input  wire l2c_pkg::way_t                  way_rd,
    input  wire l2c_pkg::way_t                  way_wr,
    input  wire [l2c_pkg::word_sel_bits-1:0]    word_sel,
    input  wire                                 fill_we,
    input  wire l2c_pkg::line_t                 fill_line,
    input  wire                                 merge_we,
    input  wire l2c_pkg::word_t                 merge_word,
    output l2c_pkg::line_t                      rd_line,
    output l2c_pkg::word_t                      rd_word
);
    import l2c_pkg::*;

    localparam int sets = 1 << set_bits;

    line_t data_q [sets][ways];

    assign rd_line = data_q[index][way_rd];
    assign rd_word = rd_line[word_sel*word_w +: word_w];   // word 0 at the low end

    always_ff @(posedge clk_tmp) begin
        if (fill_we) begin
            data_q[index][way_wr] <= fill_line;
        end else if (merge_we) begin
            data_q[index][way_wr][word_sel*word_w +: word_w] <= merge_word;
        end
    end

endmodule

`default_nettype wire

//--- source/l2c_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types and geometry for the four-way L2 cache.
// Lines are 512 bits with four 128-bit words and a 32-bit byte address.
// The tree pseudo-LRU only handles ways == 4.
// The set count is a module parameter. default_set_bits is only its default.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package l2c_pkg;

    localparam int addr_w           = 32;
    localparam int line_w           = 512;
    localparam int word_w           = 128;
    localparam int ways             = 4;
    localparam int off_bits         = 6;   // byte offset within a line
    localparam int word_sel_bits    = 2;   // address bits 5:4
    localparam int default_set_bits = 4;

    typedef logic [$clog2(ways)-1:0] way_t;
    typedef logic [word_w-1:0]       word_t;
    typedef logic [line_w-1:0]       line_t;

    typedef struct packed {
        logic              valid;
        logic              write;
        logic [addr_w-1:0] addr;
        word_t             wdata;
    } cpu_req_t;

    typedef struct packed {
        logic  ready;
        word_t rdata;
    } cpu_rsp_t;

    typedef struct packed {
        logic                       cyc;
        logic                       stb;
        logic                       we;
        logic [addr_w-off_bits-1:0] adr;   // line address, byte address >> 6
        line_t                      dat;
    } wb_m2s_t;

    typedef struct packed {
        logic  ack;
        line_t dat;
    } wb_s2m_t;

    typedef enum logic [2:0] {
        idle,
        lookup,
        write_back,
        refill,
        respond
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- source/l2c_plru.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tree pseudo-LRU, three bits per set, for exactly four ways.
// bit 0 picks the pair, bit 1 picks inside ways 0/1, bit 2 inside ways 2/3.
// The lowest invalid way is always the victim before the tree is used.
// Victim is combinational. The update lands at the edge after access.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module l2c_plru #(
    parameter int set_bits = l2c_pkg::default_set_bits
) (
    input  wire                         clk_tmp,
    input  wire                         rst,
    input  wire [set_bits-1:0]          index,
    input  wire                         access,
    input  wire l2c_pkg::way_t          used_way,
    input  wire [l2c_pkg::ways-1:0]     valid_vec,
    output l2c_pkg::way_t               victim
);
    import l2c_pkg::*;

    localparam int sets = 1 << set_bits;

    logic [2:0] tree_q [sets];
    logic [2:0] tree;

    assign tree = tree_q[index];

    always_comb begin
        if (!valid_vec[0]) begin
            victim = way_t'(0);
        end else if (!valid_vec[1]) begin
            victim = way_t'(1);
        end else if (!valid_vec[2]) begin
            victim = way_t'(2);
        end else if (!valid_vec[3]) begin
            victim = way_t'(3);
        end else if (!tree[0]) begin
            victim = {1'b0, tree[1]};   // ways 0 and 1
        end else begin
            victim = {1'b1, tree[2]};   // ways 2 and 3
        end
    end

    // point every bit on the path away from the way just used
    always_ff @(posedge clk_tmp) begin
        if (rst) begin
            for (int s = 0; s < sets; s++) begin
                tree_q[s] <= '0;
            end
        end else if (access) begin
            tree_q[index][0] <= ~used_way[1];
            if (used_way[1]) begin
                tree_q[index][2] <= ~used_way[0];
            end else begin
                tree_q[index][1] <= ~used_way[0];
            end
        end
    end

endmodule

`default_nettype wire

//--- source/l2c_tag_store.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tag, valid and dirty arrays for all four ways.
// Hit and victim status are combinational from index. Writes land at the edge.
// A tag write always targets the victim way and leaves it clean.
// Only valid is cleared by reset.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module l2c_tag_store #(
    parameter int  set_bits = l2c_pkg::default_set_bits,
    localparam int tag_w    = l2c_pkg::addr_w - set_bits - l2c_pkg::off_bits
) (
    input  wire                         clk_tmp,
    input  wire                         rst,
    input  wire [set_bits-1:0]          index,
    input  wire [tag_w-1:0]             tag,
    input  wire                         tag_we,
    input  wire                         dirty_we,
    input  wire                         dirty_val,
    input  wire l2c_pkg::way_t          victim,
    output logic                        hit,
    output l2c_pkg::way_t               hit_way,
    output logic [l2c_pkg::ways-1:0]    valid_vec,   // to the replacement logic
    output logic                        victim_valid,
    output logic                        victim_dirty,
    output logic [tag_w-1:0]            victim_tag
);
    import l2c_pkg::*;

    localparam int sets = 1 << set_bits;

    logic [ways-1:0]  valid_q [sets];
    logic [ways-1:0]  dirty_q [sets];
    logic [tag_w-1:0] tag_q   [sets][ways];
    logic [ways-1:0]  match;

    always_comb begin
        for (int w = 0; w < ways; w++) begin
            match[w] = valid_q[index][w] && (tag_q[index][w] == tag);
        end
        hit     = |match;
        hit_way = '0;
        for (int w = ways - 1; w >= 0; w--) begin   // lowest way wins
            if (match[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    assign valid_vec    = valid_q[index];
    assign victim_valid = valid_q[index][victim];
    assign victim_dirty = dirty_q[index][victim];
    assign victim_tag   = tag_q[index][victim];

    always_ff @(posedge clk_tmp) begin
        if (rst) begin
            for (int s = 0; s < sets; s++) begin
                valid_q[s] <= '0;
            end
        end else if (tag_we) begin
            valid_q[index][victim] <= 1'b1;
        end
    end

    always_ff @(posedge clk_tmp) begin
        if (tag_we) begin
            dirty_q[index][victim] <= 1'b0;   // fresh line from memory
            tag_q[index][victim]   <= tag;
        end else if (dirty_we) begin
            dirty_q[index][hit_way] <= dirty_val;
        end
    end

endmodule

`default_nettype wire

//--- source/l2c_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Four-way L2 cache top level.
// set_bits gives 2**set_bits sets, 4 by default, 9 for a 512-set build.
// Processor side is a request/ready/complete handshake. Memory side is a
// Wishbone classic master moving one 512-bit line per cycle.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module l2c_top #(
    parameter int set_bits = l2c_pkg::default_set_bits
) (
    input  wire                         clk_tmp,
    input  wire                         rst,
    input  wire l2c_pkg::cpu_req_t      req,
    input  wire                         complete,
    output l2c_pkg::cpu_rsp_t           rsp,
    output l2c_pkg::wb_m2s_t            wb_o,
    input  wire l2c_pkg::wb_s2m_t       wb_i
);
    import l2c_pkg::*;

    localparam int tag_w = addr_w - set_bits - off_bits;

    logic [set_bits-1:0]      index;
    logic [tag_w-1:0]         tag;
    logic [word_sel_bits-1:0] word_sel;
    logic                     hit;
    way_t                     hit_way;
    way_t                     victim;
    way_t                     way_sel;
    logic [ways-1:0]          valid_vec;
    logic                     victim_valid;
    logic                     victim_dirty;
    logic [tag_w-1:0]         victim_tag;
    logic                     tag_we;
    logic                     dirty_we;
    logic                     fill_we;
    logic                     merge_we;
    logic                     access;
    line_t                    fill_line;
    word_t                    merge_word;
    line_t                    rd_line;
    word_t                    rd_word;

    // hit way on a hit, else the victim for write-back and fill
    assign way_sel = hit ? hit_way : victim;

    l2c_ctrl #(.set_bits(set_bits)) u_ctrl (
        .clk_tmp      (clk_tmp),
        .rst          (rst),
        .req          (req),
        .complete     (complete),
        .rsp          (rsp),
        .hit          (hit),
        .victim_valid (victim_valid),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .rd_line      (rd_line),
        .rd_word      (rd_word),
        .index        (index),
        .tag          (tag),
        .word_sel     (word_sel),
        .tag_we       (tag_we),
        .dirty_we     (dirty_we),
        .fill_we      (fill_we),
        .merge_we     (merge_we),
        .access       (access),
        .fill_line    (fill_line),
        .merge_word   (merge_word),
        .wb_o         (wb_o),
        .wb_i         (wb_i)
    );

    l2c_tag_store #(.set_bits(set_bits)) u_tag_store (
        .clk_tmp      (clk_tmp),
        .rst          (rst),
        .index        (index),
        .tag          (tag),
        .tag_we       (tag_we),
        .dirty_we     (dirty_we),
        .dirty_val    (1'b1),   // dirty is only ever set, by write hits
        .victim       (victim),
        .hit          (hit),
        .hit_way      (hit_way),
        .valid_vec    (valid_vec),
        .victim_valid (victim_valid),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    l2c_line_store #(.set_bits(set_bits)) u_line_store (
        .clk_tmp    (clk_tmp),
        .index      (index),
        .way_rd     (way_sel),
        .way_wr     (way_sel),
        .word_sel   (word_sel),
        .fill_we    (fill_we),
        .fill_line  (fill_line),
        .merge_we   (merge_we),
        .merge_word (merge_word),
        .rd_line    (rd_line),
        .rd_word    (rd_word)
    );

    l2c_plru #(.set_bits(set_bits)) u_plru (
        .clk_tmp   (clk_tmp),
        .rst       (rst),
        .index     (index),
        .access    (access),
        .used_way  (hit_way),
        .valid_vec (valid_vec),
        .victim    (victim)
    );

endmodule

`default_nettype wire

//--- verilog.f
source/l2c_pkg.sv
source/l2c_tag_store.sv
source/l2c_line_store.sv
source/l2c_plru.sv
source/l2c_ctrl.sv
source/l2c_top.sv
sim/l2c_mem_model.sv
sim/tb_l2c.sv
